/* common/shift_pkg.sv */
// shift unit package with word widths, op codes and pipeline stage structs
`default_nettype none

package shift_pkg;

    // datapath widths
    localparam int XLEN    = 32;
    localparam int SHAMT_W = 5;
    localparam int OP_W    = 2;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [SHAMT_W-1:0] shamt_t;
    typedef logic [XLEN-1:0]    onehot_t;  // one bit per shift amount
    typedef logic [OP_W-1:0]    shift_op_t;

    // op encoding, 3 is unused and decodes as sll
    localparam shift_op_t OP_SLL = 2'd0;
    localparam shift_op_t OP_SRL = 2'd1;
    localparam shift_op_t OP_SRA = 2'd2;

    // request at the top-level port
    typedef struct packed {
        word_t     data;
        shamt_t    amount;
        shift_op_t op;
    } shift_req_t;

    // stage 1 to stage 2
    typedef struct packed {
        word_t   data;
        onehot_t sel;
        word_t   fill;   // vacated bits, already sign gated
        logic    right;
    } shift_dec_t;

    // stage 2 to stage 3
    typedef struct packed {
        word_t value;
        word_t fill;
        logic  carry;
    } shift_mid_t;

    // response at the top-level port
    typedef struct packed {
        word_t result;
        logic  carry;
        logic  zero;
    } shift_rsp_t;

endpackage

`default_nettype wire

/* rtl/shift_decoder.sv */
// shift decoder, turns amount and op into a one-hot select and a sign fill mask
`default_nettype none

module shift_decoder
    import shift_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  shift_req_t req,
    output logic       dec_valid,
    output shift_dec_t dec
);

    onehot_t sel;
    word_t   fill;
    logic    right;
    logic    sign_fill;

    // direction and arithmetic fill from the op
    always_comb begin
        right     = 1'b0;
        sign_fill = 1'b0;
        case (req.op)
            OP_SLL: begin
                right = 1'b0;
            end
            OP_SRL: begin
                right = 1'b1;
            end
            OP_SRA: begin
                right     = 1'b1;
                sign_fill = req.data[XLEN-1];   // only a negative operand fills ones
            end
            default: begin
                right = 1'b0;                   // reserved code acts as sll
            end
        endcase
    end

    // one-hot select, bit k set for a shift by k
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            sel[i] = (req.amount == shamt_t'(i));
        end
    end

    // top amount bits are vacated by a right shift
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            fill[XLEN-1-i] = sign_fill & (shamt_t'(i) < req.amount);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= in_valid;
        end
    end

    // payload only moves with a request
    always_ff @(posedge clk) begin
        if (in_valid) begin
            dec.data  <= req.data;
            dec.sel   <= sel;
            dec.fill  <= fill;
            dec.right <= right;
        end
    end

    // the matrix stage relies on exactly one amount being selected
    a_sel_onehot : assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid |-> $onehot(dec.sel)
    ) else $error("shift decoder select is not one-hot");

endmodule

`default_nettype wire

/* rtl/shift_matrix.sv */
// shift matrix, AND-OR crossbar that applies the one-hot select in either direction
`default_nettype none

module shift_matrix
    import shift_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       dec_valid,
    input  shift_dec_t dec,
    output logic       mid_valid,
    output shift_mid_t mid
);

    word_t src;       // data, reversed for right shifts
    word_t shl;       // left shifted src
    word_t value;
    logic  carry;

    function automatic word_t bit_rev(input word_t w);
        word_t r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = w[XLEN-1-i];
        end
        return r;
    endfunction

    // right shifts run through the same left crossbar on reversed data
    always_comb begin
        src = dec.right ? bit_rev(dec.data) : dec.data;
    end

    // out bit i collects src[i-k] when sel[k] is set
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            shl[i] = 1'b0;
            for (int j = 0; j <= i; j++) begin
                shl[i] = shl[i] | (dec.sel[j] & src[i-j]);
            end
        end
    end

    always_comb begin
        value = dec.right ? bit_rev(shl) : shl;
    end

    // last bit out is src[XLEN-k] in both directions, nothing leaves for k = 0
    always_comb begin
        carry = 1'b0;
        for (int k = 1; k < XLEN; k++) begin
            carry = carry | (dec.sel[k] & src[XLEN-k]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mid_valid <= 1'b0;
        end else begin
            mid_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            mid.value <= value;
            mid.fill  <= dec.fill;   // merged in the next stage
            mid.carry <= carry;
        end
    end

    // a zero shift never reports a shifted-out bit
    a_zero_amount_no_carry : assert property (
        @(posedge clk) disable iff (!rst_n)
        (dec_valid && dec.sel[0]) |=> (mid_valid && !mid.carry)
    ) else $error("shift matrix carry set for amount 0");

endmodule

`default_nettype wire

/* rtl/shift_merge.sv */
// shift merge, ORs the sign fill into the shifted word and forms the zero flag
`default_nettype none

module shift_merge
    import shift_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       mid_valid,
    input  shift_mid_t mid,
    output logic       out_valid,
    output shift_rsp_t rsp
);

    word_t merged;
    logic  zero;

    // fill only covers vacated bits, so OR is enough
    always_comb begin
        merged = mid.value | mid.fill;
        zero   = ~|merged;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= mid_valid;
        end
    end

    // rsp holds between results
    always_ff @(posedge clk) begin
        if (mid_valid) begin
            rsp.result <= merged;
            rsp.carry  <= mid.carry;
            rsp.zero   <= zero;
        end
    end

    a_zero_flag : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> (rsp.zero == (rsp.result == '0))
    ) else $error("shift merge zero flag disagrees with result");

endmodule

`default_nettype wire

/* rtl/shift_unit.sv */
// shift unit top, three stage sll/srl/sra pipeline with a plain valid strobe
`default_nettype none

module shift_unit
    import shift_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    input  shift_req_t req,
    output logic       out_valid,
    output shift_rsp_t rsp
);

    // stage 1 to 2
    logic       dec_valid;
    shift_dec_t dec;

    // stage 2 to 3
    logic       mid_valid;
    shift_mid_t mid;

    // decode amount and op
    shift_decoder u_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    // crossbar shift and carry
    shift_matrix u_matrix (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_valid (dec_valid),
        .dec       (dec),
        .mid_valid (mid_valid),
        .mid       (mid)
    );

    // fill merge and flags, drives the top outputs
    shift_merge u_merge (
        .clk       (clk),
        .rst_n     (rst_n),
        .mid_valid (mid_valid),
        .mid       (mid),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

/* dv/shift_unit_tb.sv */
// shift unit testbench with a queue based reference and assertion checks on the response
`default_nettype none

module shift_unit_tb
    import shift_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DRAIN_LIMIT = 12;   // cycles

    logic       clk;
    logic       rst_n;
    logic       in_valid;
    shift_req_t req;
    logic       out_valid;
    shift_rsp_t rsp;

    integer seed;

    shift_rsp_t exp_q[$];
    string      name_q[$];
    shift_rsp_t exp_head;
    string      head_name;
    logic       have_exp;
    logic       take;       // a response was checked on the last edge

    shift_unit u_shift_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

    always #2 clk = ~clk;

    // reference built straight from the shift rules
    function automatic shift_rsp_t expected_rsp(input word_t data, input shamt_t amount,
                                                input shift_op_t op);
        shift_rsp_t r;
        int         k;
        k = int'(amount);
        if (op == OP_SRL || op == OP_SRA) begin
            if (op == OP_SRA) begin
                r.result = word_t'($signed(data) >>> k);
            end else begin
                r.result = data >> k;
            end
            r.carry = (k == 0) ? 1'b0 : data[k-1];
        end else begin
            r.result = data << k;      // op 3 lands here too
            r.carry  = (k == 0) ? 1'b0 : data[32-k];
        end
        r.zero = (r.result == '0);
        return r;
    endfunction

    task automatic refresh_head();
        if (exp_q.size() > 0) begin
            exp_head  = exp_q[0];
            head_name = name_q[0];
            have_exp  = 1'b1;
        end else begin
            have_exp = 1'b0;
        end
    endtask

    task automatic send_req(input word_t data, input shamt_t amount, input shift_op_t op,
                            input string name);
        @(negedge clk);
        in_valid   = 1'b1;
        req.data   = data;
        req.amount = amount;
        req.op     = op;
        exp_q.push_back(expected_rsp(data, amount, op));
        name_q.push_back(name);
        refresh_head();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        idle_cycles(1);
        while (exp_q.size() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: out_valid never arrived for %0d pending requests", exp_q.size());
            $display("test failed");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            take <= 1'b0;
        end else begin
            take <= out_valid;
        end
    end

    // retire the checked entry half a cycle after the compare
    always @(negedge clk) begin
        if (take && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            void'(name_q.pop_front());
            refresh_head();
        end
    end

    a_reset_quiet : assert property (@(posedge clk) !rst_n |=> !out_valid)
        else begin
            $display("out_valid was high while reset was held");
            $display("test failed");
            $fatal(1);
        end

    a_latency : assert property (
        @(posedge clk) disable iff (!rst_n) in_valid |-> ##3 out_valid
    ) else begin
        $display("out_valid did not rise three cycles after a request");
        $display("test failed");
        $fatal(1);
    end

    a_no_extra : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> ($past(in_valid, 3) && have_exp)
    ) else begin
        $display("out_valid pulsed without a matching request");
        $display("test failed");
        $fatal(1);
    end

    a_result : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> (rsp.result == exp_head.result)
    ) else begin
        $display("ERROR %s: result expected %h actual %h", head_name, exp_head.result,
                 $sampled(rsp.result));
        $display("test failed");
        $fatal(1);
    end

    a_carry : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> (rsp.carry == exp_head.carry)
    ) else begin
        $display("ERROR %s: carry expected %b actual %b", head_name, exp_head.carry,
                 $sampled(rsp.carry));
        $display("test failed");
        $fatal(1);
    end

    a_zero : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> (rsp.zero == exp_head.zero)
    ) else begin
        $display("ERROR %s: zero expected %b actual %b", head_name, exp_head.zero,
                 $sampled(rsp.zero));
        $display("test failed");
        $fatal(1);
    end

    initial begin
        int gap;
        seed     = 8922;
        clk      = 1'b0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        req      = '0;
        have_exp = 1'b0;
        take     = 1'b0;
        exp_head = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(4);   // still nothing may come out

        for (int a = 0; a < 32; a++) begin
            send_req(word_t'($random(seed)), shamt_t'(a), OP_SLL, "sll_sweep");
        end
        for (int a = 0; a < 32; a++) begin
            send_req(word_t'($random(seed)), shamt_t'(a), OP_SRL, "srl_sweep");
        end
        wait_drain();

        // both sign polarities for sra
        for (int a = 0; a < 32; a++) begin
            send_req(word_t'($random(seed)) | 32'h8000_0000, shamt_t'(a), OP_SRA, "sra_neg");
            send_req(word_t'($random(seed)) & 32'h7fff_ffff, shamt_t'(a), OP_SRA, "sra_pos");
        end
        for (int i = 0; i < 16; i++) begin
            send_req(word_t'($random(seed)), shamt_t'($random(seed)), 2'd3, "op3_as_sll");
        end
        wait_drain();

        for (int op = 0; op < 4; op++) begin
            send_req(word_t'($random(seed)), 5'd0, shift_op_t'(op), "amount_zero");
            idle_cycles(1);
        end
        wait_drain();

        for (int op = 0; op < 3; op++) begin
            send_req(32'h0, shamt_t'($random(seed)), shift_op_t'(op), "zero_operand");
        end
        send_req(32'h8000_0000, 5'd1, OP_SLL, "zero_shift_out");
        send_req(32'h0000_0003, 5'd2, OP_SRL, "zero_shift_out");
        send_req(32'h7fff_ffff, 5'd31, OP_SRA, "zero_shift_out");
        send_req(32'h0000_0001, 5'd31, OP_SLL, "zero_clear");
        wait_drain();

        // traffic with random idle gaps
        for (int i = 0; i < 48; i++) begin
            send_req(word_t'($random(seed)), shamt_t'($random(seed)),
                     shift_op_t'($random(seed)), "mixed_traffic");
            gap = int'($unsigned($random(seed)) % 3);
            if (gap != 0) begin
                idle_cycles(gap);
            end
        end
        wait_drain();
        idle_cycles(4);

        if (exp_q.size() == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("%0d expected responses were never checked", exp_q.size());
            $display("test failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* flist.f */
common/shift_pkg.sv
rtl/shift_decoder.sv
rtl/shift_matrix.sv
rtl/shift_merge.sv
rtl/shift_unit.sv
dv/shift_unit_tb.sv
